// File: sigma_pkg.sv
// shared types and constants for the compute tile
// bus request and response structs, address decode bits and SFR map

package sigma_pkg;

    localparam int IRQ_NUM    = 16;
    localparam int IRQ_CODE_W = $clog2(IRQ_NUM);

    typedef logic [31:0]           addr_t;
    typedef logic [31:0]           data_t;
    typedef logic [3:0]            be_t;
    typedef logic [IRQ_NUM-1:0]    irq_mask_t;
    typedef logic [IRQ_CODE_W-1:0] irq_code_t;

    // request phase, qualified by a separate req/ack pair
    typedef struct packed
    {
        logic  we;
        addr_t addr;
        be_t   be;
        data_t wdata;
    } mem_req_t;

    // response phase, resp is a one-cycle strobe
    typedef struct packed
    {
        logic  resp;
        data_t rdata;
    } mem_rsp_t;

    // address decode
    localparam int XIF_BITSEL = 31;
    localparam int SFR_BITSEL = 20;

    // interrupt line driven by the SFR timer
    localparam int TIMER_IRQ = 1;

    // byte offsets inside the SFR window
    localparam addr_t SFR_CORENUM      = 32'h00;
    localparam addr_t SFR_SW_RESET     = 32'h04;
    localparam addr_t SFR_IRQ_EN       = 32'h08;
    localparam addr_t SFR_SGI          = 32'h0C;
    localparam addr_t SFR_TIMER_PERIOD = 32'h10;
    localparam addr_t SFR_TIMER_VALUE  = 32'h14;

    typedef enum logic [1:0]
    {
        SLV_RAM,
        SLV_SFR,
        SLV_XIF
    } sigma_slave_e;

endpackage

// File: sigma_irq_adapter.sv
// collects external, timer and software interrupts into pending bits
// and presents the lowest pending line as one request with a code

`timescale 1ns/10ps

module sigma_irq_adapter
    import sigma_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      core_reset_i,
    input  irq_mask_t irq_i,
    input  irq_mask_t irq_en_i,
    input  logic      timer_irq_i,
    input  logic      sgi_req_i,
    input  irq_code_t sgi_code_i,
    output logic      irq_req_o,
    output irq_code_t irq_code_o,
    input  logic      irq_ack_i
);

    irq_mask_t pending_q;
    irq_mask_t hw_set;
    irq_mask_t sgi_set;
    irq_mask_t ack_clr;

    // timer shares the mask with the external lines
    assign hw_set  = (irq_i | (irq_mask_t'(timer_irq_i) << TIMER_IRQ)) & irq_en_i;
    assign sgi_set = sgi_req_i ? (irq_mask_t'(1) << sgi_code_i) : '0;
    assign ack_clr = irq_ack_i ? (irq_mask_t'(1) << irq_code_o) : '0;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
            pending_q <= '0;
        else if (core_reset_i)
            pending_q <= '0;
        else
            pending_q <= (pending_q & ~ack_clr) | hw_set | sgi_set;
    end

    // lowest line wins
    always_comb
    begin
        irq_code_o = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--)
        begin
            if (pending_q[i])
                irq_code_o = irq_code_t'(i);
        end
    end

    assign irq_req_o = |pending_q;

    a_ack_with_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        irq_ack_i |-> irq_req_o);

endmodule

// File: sigma_sfr.sv
// special function registers of the tile: core id, core reset,
// interrupt enables, countdown timer and software interrupt trigger

`timescale 1ns/10ps

module sigma_sfr
    import sigma_pkg::*;
#(
    parameter data_t CORENUM          = '0,
    parameter logic  SW_RESET_DEFAULT = 1'b0
)
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      req_i,
    input  mem_req_t  bus_i,
    output logic      ack_o,
    output mem_rsp_t  rsp_o,
    output irq_mask_t irq_en_o,
    output logic      timer_irq_o,
    output logic      sgi_req_o,
    output irq_code_t sgi_code_o,
    output logic      core_reset_o
);

    addr_t     offset;
    logic      wr;
    logic      rd;
    data_t     rd_data;
    logic      sw_reset_q;
    irq_mask_t irq_en_q;
    data_t     period_q;
    data_t     timer_q;
    logic      timer_irq_q;
    logic      sgi_req_q;
    irq_code_t sgi_code_q;
    logic      resp_q;
    data_t     rdata_q;

    // always ready
    assign ack_o  = req_i;
    assign wr     = req_i && bus_i.we;
    assign rd     = req_i && !bus_i.we;
    assign offset = addr_t'(bus_i.addr[SFR_BITSEL-1:0]);

    always_comb
    begin
        case (offset)
            SFR_CORENUM:      rd_data = CORENUM;
            SFR_SW_RESET:     rd_data = data_t'(sw_reset_q);
            SFR_IRQ_EN:       rd_data = data_t'(irq_en_q);
            SFR_TIMER_PERIOD: rd_data = period_q;
            SFR_TIMER_VALUE:  rd_data = timer_q;
            default:          rd_data = '0;
        endcase
    end

    // registers are written as whole words
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            sw_reset_q <= SW_RESET_DEFAULT;
            irq_en_q   <= '0;
            sgi_req_q  <= 1'b0;
            sgi_code_q <= '0;
        end
        else
        begin
            sgi_req_q <= wr && (offset == SFR_SGI);
            if (wr && (offset == SFR_SW_RESET))
                sw_reset_q <= bus_i.wdata[0];
            if (wr && (offset == SFR_IRQ_EN))
                irq_en_q <= irq_mask_t'(bus_i.wdata);
            if (wr && (offset == SFR_SGI))
                sgi_code_q <= irq_code_t'(bus_i.wdata);
        end
    end

    // countdown, reload from period at zero
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            period_q    <= '0;
            timer_q     <= '0;
            timer_irq_q <= 1'b0;
        end
        else
        begin
            timer_irq_q <= 1'b0;
            if (wr && (offset == SFR_TIMER_PERIOD))
            begin
                period_q <= bus_i.wdata;
                timer_q  <= bus_i.wdata;
            end
            else if (period_q == '0)
                timer_q <= '0;
            else if (timer_q == '0)
            begin
                timer_q     <= period_q;
                timer_irq_q <= 1'b1;
            end
            else
                timer_q <= timer_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
            resp_q <= 1'b0;
        else
            resp_q <= rd;
    end

    always_ff @(posedge clk_i)
    begin
        if (rd)
            rdata_q <= rd_data;
    end

    assign rsp_o        = '{resp: resp_q, rdata: rdata_q};
    assign irq_en_o     = irq_en_q;
    assign timer_irq_o  = timer_irq_q;
    assign sgi_req_o    = sgi_req_q;
    assign sgi_code_o   = sgi_code_q;
    assign core_reset_o = sw_reset_q;

    // software must not write the trigger on back-to-back cycles
    a_sgi_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        sgi_req_o |=> !sgi_req_o);

endmodule

// File: sigma_ram.sv
// local data RAM, one word per entry with byte-masked writes
// accepts a request every cycle and answers reads on the next cycle

`timescale 1ns/10ps

module sigma_ram
    import sigma_pkg::*;
#(
    parameter int MEM_WORDS = 1024
)
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     req_i,
    input  mem_req_t bus_i,
    output logic     ack_o,
    output mem_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    data_t             mem [MEM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic              resp_q;
    data_t             rdata_q;

    // word address wraps at the array size
    assign idx   = bus_i.addr[IDX_W+1:2];
    assign ack_o = req_i;

    always_ff @(posedge clk_i)
    begin
        if (req_i && bus_i.we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (bus_i.be[b])
                    mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
            end
        end
        if (req_i && !bus_i.we)
            rdata_q <= mem[idx];
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
            resp_q <= 1'b0;
        else
            resp_q <= req_i && !bus_i.we;
    end

    assign rsp_o = '{resp: resp_q, rdata: rdata_q};

    a_write_be: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (req_i && bus_i.we) |-> (bus_i.be != '0));

endmodule

// File: sigma_arb.sv
// path-through interconnect, host and core masters onto RAM, SFR and expansion
// host has priority, read responses are routed back in order by a small queue

`timescale 1ns/10ps

module sigma_arb
    import sigma_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     m0_req_i,
    input  mem_req_t m0_i,
    output logic     m0_ack_o,
    output mem_rsp_t m0_rsp_o,

    input  logic     m1_req_i,
    input  mem_req_t m1_i,
    output logic     m1_ack_o,
    output mem_rsp_t m1_rsp_o,

    output logic     ram_req_o,
    output mem_req_t ram_o,
    input  logic     ram_ack_i,
    input  mem_rsp_t ram_rsp_i,

    output logic     sfr_req_o,
    output mem_req_t sfr_o,
    input  logic     sfr_ack_i,
    input  mem_rsp_t sfr_rsp_i,

    output logic     xif_req_o,
    output mem_req_t xif_o,
    input  logic     xif_ack_i,
    input  mem_rsp_t xif_rsp_i
);

    localparam int QDEPTH = 4;
    localparam int PTR_W  = $clog2(QDEPTH);

    typedef struct packed
    {
        logic         mst;
        sigma_slave_e slv;
    } rq_entry_t;

    rq_entry_t      rq_mem [QDEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0] count_q;
    logic           lock_q;
    logic           lock_mst_q;

    logic           mst_sel;
    logic           any_req;
    mem_req_t       req_sel;
    sigma_slave_e   slv_sel;
    logic           slv_ack;
    logic           stall;
    logic           fwd;
    logic           accept;
    logic           push;
    logic           pop;
    logic           q_empty;
    rq_entry_t      q_head;
    mem_rsp_t       rsp_head;

    function automatic sigma_slave_e decode(addr_t addr);
        if (addr[XIF_BITSEL])
            return SLV_XIF;
        else if (addr[SFR_BITSEL])
            return SLV_SFR;
        return SLV_RAM;
    endfunction

    // keep the grant on a master whose request is waiting for ack
    assign mst_sel = lock_q ? lock_mst_q : !m0_req_i;
    assign any_req = mst_sel ? m1_req_i : m0_req_i;
    assign req_sel = mst_sel ? m1_i : m0_i;
    assign slv_sel = decode(req_sel.addr);

    assign q_empty = (count_q == '0);
    assign q_head  = rq_mem[rd_ptr_q];

    // reads wait while the queue is full or busy with another slave
    assign stall = !req_sel.we
                && ((count_q == QDEPTH) || (!q_empty && (q_head.slv != slv_sel)));
    assign fwd   = any_req && !stall;

    assign ram_req_o = fwd && (slv_sel == SLV_RAM);
    assign sfr_req_o = fwd && (slv_sel == SLV_SFR);
    assign xif_req_o = fwd && (slv_sel == SLV_XIF);
    assign ram_o     = req_sel;
    assign sfr_o     = req_sel;
    assign xif_o     = req_sel;

    always_comb
    begin
        case (slv_sel)
            SLV_SFR: slv_ack = sfr_ack_i;
            SLV_XIF: slv_ack = xif_ack_i;
            default: slv_ack = ram_ack_i;
        endcase
    end

    assign accept   = fwd && slv_ack;
    assign push     = accept && !req_sel.we;
    assign m0_ack_o = accept && !mst_sel;
    assign m1_ack_o = accept && mst_sel;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            lock_q     <= 1'b0;
            lock_mst_q <= 1'b0;
        end
        else if (accept)
            lock_q <= 1'b0;
        else if (fwd)
        begin
            lock_q     <= 1'b1;
            lock_mst_q <= mst_sel;
        end
    end

    // only the head slave can have responses in flight
    always_comb
    begin
        case (q_head.slv)
            SLV_SFR: rsp_head = sfr_rsp_i;
            SLV_XIF: rsp_head = xif_rsp_i;
            default: rsp_head = ram_rsp_i;
        endcase
    end

    assign pop      = rsp_head.resp && !q_empty;
    assign m0_rsp_o = '{resp: pop && !q_head.mst, rdata: rsp_head.rdata};
    assign m1_rsp_o = '{resp: pop && q_head.mst, rdata: rsp_head.rdata};

    always_ff @(posedge clk_i)
    begin
        if (push)
            rq_mem[wr_ptr_q] <= '{mst: mst_sel, slv: slv_sel};
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_no_orphan_rsp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ram_rsp_i.resp || sfr_rsp_i.resp || xif_rsp_i.resp) |-> !q_empty);

    a_one_slave_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({ram_req_o, sfr_req_o, xif_req_o}));

endmodule

// File: sigma_tile.sv
// top level of the compute tile without its core
// host and core data ports share the RAM, SFR block and expansion port

`timescale 1ns/10ps

module sigma_tile
    import sigma_pkg::*;
#(
    parameter data_t CORENUM          = '0,
    parameter int    MEM_WORDS        = 1024,
    parameter logic  SW_RESET_DEFAULT = 1'b0
)
(
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  irq_mask_t irq_i,

    input  logic      host_req_i,
    input  mem_req_t  host_i,
    output logic      host_ack_o,
    output mem_rsp_t  host_rsp_o,

    input  logic      core_req_i,
    input  mem_req_t  core_i,
    output logic      core_ack_o,
    output mem_rsp_t  core_rsp_o,

    output logic      xif_req_o,
    output mem_req_t  xif_o,
    input  logic      xif_ack_i,
    input  mem_rsp_t  xif_rsp_i,

    output logic      core_reset_o,

    output logic      irq_req_o,
    output irq_code_t irq_code_o,
    input  logic      irq_ack_i
);

    logic      ram_req;
    mem_req_t  ram_bus;
    logic      ram_ack;
    mem_rsp_t  ram_rsp;

    logic      sfr_req;
    mem_req_t  sfr_bus;
    logic      sfr_ack;
    mem_rsp_t  sfr_rsp;

    irq_mask_t irq_en;
    logic      timer_irq;
    logic      sgi_req;
    irq_code_t sgi_code;

    sigma_arb u_arb (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .m0_req_i  (host_req_i),
        .m0_i      (host_i),
        .m0_ack_o  (host_ack_o),
        .m0_rsp_o  (host_rsp_o),
        .m1_req_i  (core_req_i),
        .m1_i      (core_i),
        .m1_ack_o  (core_ack_o),
        .m1_rsp_o  (core_rsp_o),
        .ram_req_o (ram_req),
        .ram_o     (ram_bus),
        .ram_ack_i (ram_ack),
        .ram_rsp_i (ram_rsp),
        .sfr_req_o (sfr_req),
        .sfr_o     (sfr_bus),
        .sfr_ack_i (sfr_ack),
        .sfr_rsp_i (sfr_rsp),
        .xif_req_o (xif_req_o),
        .xif_o     (xif_o),
        .xif_ack_i (xif_ack_i),
        .xif_rsp_i (xif_rsp_i)
    );

    sigma_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (ram_req),
        .bus_i    (ram_bus),
        .ack_o    (ram_ack),
        .rsp_o    (ram_rsp)
    );

    sigma_sfr #(
        .CORENUM          (CORENUM),
        .SW_RESET_DEFAULT (SW_RESET_DEFAULT)
    ) u_sfr (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (sfr_req),
        .bus_i        (sfr_bus),
        .ack_o        (sfr_ack),
        .rsp_o        (sfr_rsp),
        .irq_en_o     (irq_en),
        .timer_irq_o  (timer_irq),
        .sgi_req_o    (sgi_req),
        .sgi_code_o   (sgi_code),
        .core_reset_o (core_reset_o)
    );

    // interrupt state follows the software core reset
    sigma_irq_adapter u_irq (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .core_reset_i (core_reset_o),
        .irq_i        (irq_i),
        .irq_en_i     (irq_en),
        .timer_irq_i  (timer_irq),
        .sgi_req_i    (sgi_req),
        .sgi_code_i   (sgi_code),
        .irq_req_o    (irq_req_o),
        .irq_code_o   (irq_code_o),
        .irq_ack_i    (irq_ack_i)
    );

endmodule

// File: tb_sigma_tile.sv
// testbench for the compute tile with random host and core traffic against a RAM model
// plus an expansion-port responder, SFR accesses and interrupt checks

`timescale 1ns/10ps

module tb_sigma_tile
    import sigma_pkg::*;
();

    localparam int          CLK_PERIOD  = 40;
    localparam data_t       CORENUM_VAL = 32'h0000_0005;
    localparam int          MEM_WORDS   = 1024;
    localparam logic        SW_RST_DEF  = 1'b0;
    localparam logic [31:0] SEED        = 32'h4c7f_67b9;
    localparam data_t       XIF_PATTERN = 32'hA5A5_A5A5;
    localparam addr_t       SFR_BASE    = 32'h0010_0000;
    localparam int          RAM_SPAN    = 64;
    localparam int          RANDOM_OPS  = 300;
    localparam int          TIMER_P     = 8;
    // random phase needs about 1500 cycles and the directed parts a few hundred
    localparam int          MAX_CYCLES  = 20000;

    logic      clk;
    logic      arst_n;
    irq_mask_t irq;
    logic      host_req;
    mem_req_t  host_bus;
    logic      host_ack;
    mem_rsp_t  host_rsp;
    logic      core_req;
    mem_req_t  core_bus;
    logic      core_ack;
    mem_rsp_t  core_rsp;
    logic      xif_req;
    mem_req_t  xif_bus;
    logic      xif_ack;
    mem_rsp_t  xif_rsp;
    logic      core_reset;
    logic      irq_req;
    irq_code_t irq_code;
    logic      irq_ack;

    logic [31:0] stim_seed;
    logic [31:0] xif_seed;
    string       test_name;
    data_t       ram_model [RAM_SPAN];
    data_t       host_exp_q [$];
    data_t       core_exp_q [$];
    data_t       xif_rd_q [$];
    int          ack_wait;
    int          rsp_wait;

    sigma_tile #(
        .CORENUM          (CORENUM_VAL),
        .MEM_WORDS        (MEM_WORDS),
        .SW_RESET_DEFAULT (SW_RST_DEF)
    ) u_sigma_tile (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .irq_i        (irq),
        .host_req_i   (host_req),
        .host_i       (host_bus),
        .host_ack_o   (host_ack),
        .host_rsp_o   (host_rsp),
        .core_req_i   (core_req),
        .core_i       (core_bus),
        .core_ack_o   (core_ack),
        .core_rsp_o   (core_rsp),
        .xif_req_o    (xif_req),
        .xif_o        (xif_bus),
        .xif_ack_i    (xif_ack),
        .xif_rsp_i    (xif_rsp),
        .core_reset_o (core_reset),
        .irq_req_o    (irq_req),
        .irq_code_o   (irq_code),
        .irq_ack_i    (irq_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        stop_run();
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic data_t next_rand();
        stim_seed = lcg_step(stim_seed);
        return stim_seed;
    endfunction

    // low LCG bits have short periods so use the high half
    function automatic int rand_below(input int n);
        data_t r;
        r = next_rand();
        return int'(r[31:16]) % n;
    endfunction

    function automatic mem_req_t make_request();
        mem_req_t r;
        data_t    pick;
        addr_t    xa;
        pick    = next_rand();
        xa      = next_rand();
        r.we    = pick[27];
        r.wdata = next_rand();
        r.be    = pick[23:20];
        if (!r.we)
            r.be = 4'hF;
        else if (r.be == '0)
            r.be = 4'h1;
        // a quarter of the traffic goes to the expansion port
        if (pick[31:30] == 2'b11)
            r.addr = {1'b1, xa[30:2], 2'b00};
        else
            r.addr = {24'h0, pick[13:8], 2'b00};
        return r;
    endfunction

    // expansion slave with a random ack stall and in-order read data after a random gap
    always
    begin
        @(posedge clk);
        if (arst_n && xif_req && xif_ack)
        begin
            if (!xif_bus.we)
                xif_rd_q.push_back(xif_bus.addr ^ XIF_PATTERN);
            xif_seed = lcg_step(xif_seed);
            ack_wait = int'(xif_seed[25:24]);
        end
        @(negedge clk);
        if (ack_wait > 0)
        begin
            xif_ack  = 1'b0;
            ack_wait = ack_wait - 1;
        end
        else
            xif_ack = 1'b1;
        xif_rsp = '0;
        if (xif_rd_q.size() > 0)
        begin
            if (rsp_wait > 0)
                rsp_wait = rsp_wait - 1;
            else
            begin
                xif_rsp.resp  = 1'b1;
                xif_rsp.rdata = xif_rd_q.pop_front();
                xif_seed      = lcg_step(xif_seed);
                rsp_wait      = int'(xif_seed[27:26]);
            end
        end
    end

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (act !== exp)
        begin
            $display("error: %s, %s expected %h actual %h", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_code(input string what, input irq_code_t exp, input irq_code_t act);
        if (act !== exp)
        begin
            $display("error: %s, %s expected %0d actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("error: %s, %s expected %b actual %b", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic host_access(input logic we, input addr_t addr, input be_t be,
                               input data_t wdata, output data_t rdata);
        @(negedge clk);
        host_req = 1'b1;
        host_bus = '{we: we, addr: addr, be: be, wdata: wdata};
        @(posedge clk);
        while (!host_ack)
            @(posedge clk);
        @(negedge clk);
        host_req = 1'b0;
        rdata    = '0;
        if (!we)
        begin
            @(posedge clk);
            while (!host_rsp.resp)
                @(posedge clk);
            rdata = host_rsp.rdata;
        end
    endtask

    task automatic host_write(input addr_t addr, input data_t wdata);
        data_t unused_rdata;
        host_access(1'b1, addr, 4'hF, wdata, unused_rdata);
    endtask

    task automatic host_read(input addr_t addr, output data_t rdata);
        host_access(1'b0, addr, 4'hF, '0, rdata);
    endtask

    task automatic check_reset_state();
        test_name = "reset";
        @(posedge clk);
        check_bit("host ack", 1'b0, host_ack);
        check_bit("core ack", 1'b0, core_ack);
        check_bit("host resp", 1'b0, host_rsp.resp);
        check_bit("core resp", 1'b0, core_rsp.resp);
        check_bit("expansion req", 1'b0, xif_req);
        check_bit("irq request", 1'b0, irq_req);
        check_bit("core reset", SW_RST_DEF, core_reset);
    endtask

    task automatic preload_ram();
        test_name = "ram preload";
        for (int i = 0; i < RAM_SPAN; i++)
        begin
            ram_model[i] = next_rand();
            host_write(addr_t'(i * 4), ram_model[i]);
        end
    endtask

    task automatic expect_read(input int m, input data_t d);
        if (m == 0)
            host_exp_q.push_back(d);
        else
            core_exp_q.push_back(d);
    endtask

    task automatic take_response(input int m, input data_t act);
        if (m == 0)
        begin
            if (host_exp_q.size() == 0)
            begin
                $display("host port got a read response with no read outstanding");
                stop_run();
            end
            else
                check_data("host read data", host_exp_q.pop_front(), act);
        end
        else
        begin
            if (core_exp_q.size() == 0)
            begin
                $display("core port got a read response with no read outstanding");
                stop_run();
            end
            else
                check_data("core read data", core_exp_q.pop_front(), act);
        end
    endtask

    task automatic accept_request(input int m, input mem_req_t r);
        int idx;
        idx = int'(r.addr[7:2]);
        if (r.addr[XIF_BITSEL])
        begin
            check_bit("expansion req", 1'b1, xif_req);
            check_data("expansion address", r.addr, xif_bus.addr);
            check_bit("expansion write enable", r.we, xif_bus.we);
            check_data("expansion byte enables", data_t'(r.be), data_t'(xif_bus.be));
            if (r.we)
                check_data("expansion write data", r.wdata, xif_bus.wdata);
            else
                expect_read(m, r.addr ^ XIF_PATTERN);
        end
        else if (r.we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (r.be[b])
                    ram_model[idx][8*b +: 8] = r.wdata[8*b +: 8];
            end
        end
        else
            expect_read(m, ram_model[idx]);
    endtask

    task automatic run_random(input int n_ops);
        mem_req_t pend [2];
        logic     busy [2];
        int       issued [2];
        int       accepted [2];
        test_name = "random traffic";
        for (int m = 0; m < 2; m++)
        begin
            pend[m]     = '0;
            busy[m]     = 1'b0;
            issued[m]   = 0;
            accepted[m] = 0;
        end
        while (issued[0] < n_ops || issued[1] < n_ops || busy[0] || busy[1]
               || host_exp_q.size() > 0 || core_exp_q.size() > 0)
        begin
            @(negedge clk);
            for (int m = 0; m < 2; m++)
            begin
                if (!busy[m] && issued[m] < n_ops && rand_below(4) != 0)
                begin
                    pend[m]   = make_request();
                    busy[m]   = 1'b1;
                    issued[m] = issued[m] + 1;
                end
            end
            host_req = busy[0];
            host_bus = pend[0];
            core_req = busy[1];
            core_bus = pend[1];
            @(posedge clk);
            // every ack pulse counts, so an ack without a request shows up
            if (host_ack)
                accepted[0] = accepted[0] + 1;
            if (core_ack)
                accepted[1] = accepted[1] + 1;
            if (host_req && host_ack)
            begin
                accept_request(0, pend[0]);
                busy[0] = 1'b0;
            end
            if (core_req && core_ack)
            begin
                accept_request(1, pend[1]);
                busy[1] = 1'b0;
            end
            if (host_rsp.resp)
                take_response(0, host_rsp.rdata);
            if (core_rsp.resp)
                take_response(1, core_rsp.rdata);
        end
        @(negedge clk);
        host_req = 1'b0;
        core_req = 1'b0;
        check_data("host transfers", data_t'(n_ops), data_t'(accepted[0]));
        check_data("core transfers", data_t'(n_ops), data_t'(accepted[1]));
    endtask

    task automatic test_sfr();
        data_t rd;
        test_name = "sfr access";
        host_read(SFR_BASE + SFR_CORENUM, rd);
        check_data("core id", CORENUM_VAL, rd);
        host_write(SFR_BASE + SFR_IRQ_EN, 32'hBEEF_A5A4);
        host_read(SFR_BASE + SFR_IRQ_EN, rd);
        check_data("irq enables", 32'h0000_A5A4, rd);
        host_write(SFR_BASE + SFR_TIMER_PERIOD, 32'h0001_2345);
        host_read(SFR_BASE + SFR_TIMER_PERIOD, rd);
        check_data("timer period", 32'h0001_2345, rd);
        host_write(SFR_BASE + SFR_TIMER_PERIOD, 32'h0);
        host_write(SFR_BASE + SFR_SGI, 32'h9);
        host_read(SFR_BASE + SFR_SGI, rd);
        check_data("sgi readback", 32'h0, rd);
        host_read(SFR_BASE + 32'h20, rd);
        check_data("unmapped offset", 32'h0, rd);
        host_write(SFR_BASE + SFR_SW_RESET, 32'h1);
        @(posedge clk);
        check_bit("core reset set", 1'b1, core_reset);
        host_read(SFR_BASE + SFR_SW_RESET, rd);
        check_data("sw reset readback", 32'h1, rd);
        host_write(SFR_BASE + SFR_SW_RESET, 32'h0);
        @(posedge clk);
        check_bit("core reset clear", 1'b0, core_reset);
        check_bit("irq cleared by core reset", 1'b0, irq_req);
        host_write(SFR_BASE + SFR_IRQ_EN, 32'h0);
    endtask

    task automatic wait_irq(input int limit, output logic seen);
        seen = 1'b0;
        for (int k = 0; k < limit && !seen; k++)
        begin
            @(posedge clk);
            seen = irq_req;
        end
    endtask

    task automatic ack_irq();
        @(negedge clk);
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        @(posedge clk);
    endtask

    task automatic expect_quiet(input int cycles);
        for (int k = 0; k < cycles; k++)
        begin
            @(posedge clk);
            check_bit("irq request stays low", 1'b0, irq_req);
        end
    endtask

    task automatic test_timer();
        logic seen;
        test_name = "timer interrupt";
        host_write(SFR_BASE + SFR_IRQ_EN, 32'h1 << TIMER_IRQ);
        host_write(SFR_BASE + SFR_TIMER_PERIOD, TIMER_P);
        wait_irq(TIMER_P + 3, seen);
        check_bit("first expiry request", 1'b1, seen);
        check_code("first expiry code", irq_code_t'(TIMER_IRQ), irq_code);
        ack_irq();
        check_bit("request after ack", 1'b0, irq_req);
        wait_irq(TIMER_P + 3, seen);
        check_bit("second expiry request", 1'b1, seen);
        check_code("second expiry code", irq_code_t'(TIMER_IRQ), irq_code);
        ack_irq();
        host_write(SFR_BASE + SFR_IRQ_EN, 32'h0);
        test_name = "timer masked";
        expect_quiet(3 * (TIMER_P + 3));
        host_write(SFR_BASE + SFR_TIMER_PERIOD, 32'h0);
    endtask

    task automatic test_sgi_ext();
        logic seen;
        test_name = "software and external interrupts";
        host_write(SFR_BASE + SFR_IRQ_EN, 32'h1 << 3);
        host_write(SFR_BASE + SFR_SGI, 32'h7);
        wait_irq(3, seen);
        check_bit("sgi request", 1'b1, seen);
        check_code("sgi code", 4'd7, irq_code);
        // line 5 stays masked
        @(negedge clk);
        irq = (irq_mask_t'(1) << 3) | (irq_mask_t'(1) << 5);
        @(negedge clk);
        irq = '0;
        @(posedge clk);
        check_bit("request with line 3", 1'b1, irq_req);
        check_code("lowest line first", 4'd3, irq_code);
        ack_irq();
        check_bit("request after first ack", 1'b1, irq_req);
        check_code("code after first ack", 4'd7, irq_code);
        ack_irq();
        check_bit("request after second ack", 1'b0, irq_req);
        expect_quiet(10);
    endtask

    initial
    begin
        stim_seed = SEED;
        xif_seed  = ~SEED;
        ack_wait  = 0;
        rsp_wait  = 0;
        arst_n    = 1'b0;
        irq       = '0;
        host_req  = 1'b0;
        host_bus  = '0;
        core_req  = 1'b0;
        core_bus  = '0;
        xif_ack   = 1'b0;
        xif_rsp   = '0;
        irq_ack   = 1'b0;
        test_name = "reset";
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_reset_state();
        preload_ram();
        run_random(RANDOM_OPS);
        test_sfr();
        test_timer();
        test_sgi_ext();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: vlog.f
sigma_pkg.sv
sigma_irq_adapter.sv
sigma_sfr.sv
sigma_ram.sv
sigma_arb.sv
sigma_tile.sv
tb_sigma_tile.sv

// File: Makefile
TOP := tb_sigma_tile

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module sigma_tile

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
